//--- design/wb_pkg.sv
package wb_pkg;

  // bus widths
  localparam int ADR_W = 32;
  localparam int DAT_W = 32;
  localparam int SEL_W = DAT_W / 8;

  // word offset inside one slave window
  localparam int WOFF_W = 4;

  // master side request, held stable by the master until ack or err
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [SEL_W-1:0] sel;
    logic [ADR_W-1:0] adr;
    logic [DAT_W-1:0] dat;
  } wb_req_t;

  // response, used on both the slave and the master side
  typedef struct packed {
    logic             ack;
    logic             err;
    logic [DAT_W-1:0] dat;
  } wb_rsp_t;

  // slave side request with the address already rebased
  typedef struct packed {
    logic              stb;
    logic              we;
    logic [SEL_W-1:0]  sel;
    logic [WOFF_W-1:0] adr;
    logic [DAT_W-1:0]  dat;
  } wbs_req_t;

endpackage

//--- design/map_pkg.sv
package map_pkg;

  localparam int NUM_SLAVES = 4;

  // byte base address of each slave window, slave 0 in the low slot
  localparam logic [NUM_SLAVES-1:0][wb_pkg::ADR_W-1:0] SLAVE_BASE = {
    32'h0000_4000,
    32'h0000_3000,
    32'h0000_2000,
    32'h0000_1000
  };

  // sixteen words per window
  localparam logic [wb_pkg::ADR_W-1:0] SLAVE_SPAN = 32'h0000_0040;

  // only the lower half of each window is backed by registers
  localparam int REG_COUNT = 8;
  localparam int REG_IDX_W = $clog2(REG_COUNT);

  // wait cycles after the strobe before a missing ack turns into an error
  localparam int TIMEOUT_CYCLES = 8;
  localparam int TMO_W = $clog2(TIMEOUT_CYCLES + 1);

endpackage

//--- design/wbs_decoder.sv
`timescale 1ns/1ps

module wbs_decoder (
  input  logic                            wb_clk_i,
  input  logic                            wb_rst_i,
  input  wb_pkg::wb_req_t                 wbm_req_i,
  input  logic [map_pkg::NUM_SLAVES-1:0]  slv_ack_i,
  input  logic                            done_i,
  output wb_pkg::wbs_req_t                wbs_req_o [map_pkg::NUM_SLAVES],
  output logic [map_pkg::NUM_SLAVES-1:0]  active_o,
  output logic                            dec_err_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_END
  } state_t;

  state_t                                                  state;
  wb_pkg::wb_req_t                                         req_q;
  logic [map_pkg::NUM_SLAVES-1:0][wb_pkg::ADR_W-1:0]       rel;
  logic [map_pkg::NUM_SLAVES-1:0]                          hit;
  logic [wb_pkg::WOFF_W-1:0]                               hit_off;
  logic [map_pkg::NUM_SLAVES-1:0]                          stb_q;
  logic [map_pkg::NUM_SLAVES-1:0]                          active_q;
  logic                                                    dec_err_q;
  logic [map_pkg::TMO_W-1:0]                               tmo_cnt;
  logic                                                    done_seen;
  logic                                                    we_q;
  logic [wb_pkg::SEL_W-1:0]                                sel_q;
  logic [wb_pkg::WOFF_W-1:0]                               woff_q;
  logic [wb_pkg::DAT_W-1:0]                                dat_q;

  // input stage, the FSM only ever looks at the registered request
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      req_q <= '0;
    end else begin
      req_q <= wbm_req_i;
    end
  end

  // window match; an address below the base wraps and fails the span test
  always_comb begin
    hit_off = '0;
    for (int i = 0; i < map_pkg::NUM_SLAVES; i++) begin
      rel[i] = req_q.adr - map_pkg::SLAVE_BASE[i];
      hit[i] = (rel[i] < map_pkg::SLAVE_SPAN);
      if (hit[i]) begin
        hit_off = rel[i][wb_pkg::WOFF_W+1:2];
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state     <= ST_IDLE;
      stb_q     <= '0;
      active_q  <= '0;
      dec_err_q <= 1'b0;
      tmo_cnt   <= '0;
      done_seen <= 1'b0;
    end else begin
      // strobe and error are single cycle pulses
      stb_q     <= '0;
      dec_err_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          done_seen <= 1'b0;
          if (req_q.cyc && req_q.stb) begin
            if (|hit) begin
              stb_q    <= hit;
              active_q <= hit;
              tmo_cnt  <= '0;
              state    <= ST_WAIT;
            end else begin
              dec_err_q <= 1'b1;
              state     <= ST_END;
            end
          end
        end
        ST_WAIT: begin
          if (|(slv_ack_i & active_q)) begin
            state <= ST_END;
          end else if (tmo_cnt == map_pkg::TMO_W'(map_pkg::TIMEOUT_CYCLES)) begin
            // slave never answered
            dec_err_q <= 1'b1;
            state     <= ST_END;
          end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        ST_END: begin
          if (done_i) begin
            done_seen <= 1'b1;
          end
          // master must have dropped cyc before the next request is taken
          if ((done_seen || done_i) && !req_q.cyc) begin
            active_q <= '0;
            state    <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // request payload, captured while idle
  always_ff @(posedge wb_clk_i) begin
    if (state == ST_IDLE) begin
      we_q   <= req_q.we;
      sel_q  <= req_q.sel;
      woff_q <= hit_off;
      dat_q  <= req_q.dat;
    end
  end

  for (genvar i = 0; i < map_pkg::NUM_SLAVES; i++) begin : g_port
    assign wbs_req_o[i] = '{
      stb: stb_q[i],
      we:  we_q,
      sel: sel_q,
      adr: woff_q,
      dat: dat_q
    };
  end

  assign active_o  = active_q;
  assign dec_err_o = dec_err_q;

endmodule

//--- design/wb_reg_slave.sv
`timescale 1ns/1ps

module wb_reg_slave (
  input  logic             wb_clk_i,
  input  logic             wb_rst_i,
  input  wb_pkg::wbs_req_t req_i,
  output wb_pkg::wb_rsp_t  rsp_o
);

  logic [wb_pkg::DAT_W-1:0]      regs [map_pkg::REG_COUNT];
  logic                          hit;
  logic [map_pkg::REG_IDX_W-1:0] idx;
  logic                          ack_q;
  logic [wb_pkg::DAT_W-1:0]      dat_q;

  // upper half of the window is left unanswered
  assign hit = req_i.stb && (req_i.adr < wb_pkg::WOFF_W'(map_pkg::REG_COUNT));
  assign idx = req_i.adr[map_pkg::REG_IDX_W-1:0];

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
      for (int i = 0; i < map_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      ack_q <= hit;
      if (hit && req_i.we) begin
        // byte lane write
        for (int b = 0; b < wb_pkg::SEL_W; b++) begin
          if (req_i.sel[b]) begin
            regs[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
          end
        end
      end
    end
  end

  // read data returns the word as it was before any write in the same cycle
  always_ff @(posedge wb_clk_i) begin
    if (hit) begin
      dat_q <= regs[idx];
    end
  end

  assign rsp_o = '{
    ack: ack_q,
    err: 1'b0,
    dat: dat_q
  };

endmodule

//--- design/wbs_resp_mux.sv
`timescale 1ns/1ps

module wbs_resp_mux (
  input  logic                           wb_clk_i,
  input  logic                           wb_rst_i,
  input  wb_pkg::wb_rsp_t                slv_rsp_i [map_pkg::NUM_SLAVES],
  input  logic [map_pkg::NUM_SLAVES-1:0] active_i,
  input  logic                           dec_err_i,
  output wb_pkg::wb_rsp_t                wbm_rsp_o,
  output logic                           done_o
);

  logic                     ack_hit;
  logic [wb_pkg::DAT_W-1:0] sel_dat;
  logic                     ack_q;
  logic                     err_q;
  logic [wb_pkg::DAT_W-1:0] dat_q;
  logic                     done_q;

  // only the slave that owns the transfer may answer
  always_comb begin
    ack_hit = 1'b0;
    sel_dat = '0;
    for (int i = 0; i < map_pkg::NUM_SLAVES; i++) begin
      if (active_i[i]) begin
        ack_hit = ack_hit | slv_rsp_i[i].ack;
        sel_dat = sel_dat | slv_rsp_i[i].dat;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      ack_q  <= ack_hit;
      err_q  <= dec_err_i;
      // tells the decoder the master has its answer
      done_q <= ack_hit | dec_err_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (ack_hit) begin
      dat_q <= sel_dat;
    end
  end

  assign wbm_rsp_o = '{
    ack: ack_q,
    err: err_q,
    dat: dat_q
  };
  assign done_o = done_q;

endmodule

//--- design/wb_interconnect_top.sv
`timescale 1ns/1ps

module wb_interconnect_top (
  input  logic            wb_clk_i,
  input  logic            wb_rst_i,
  input  wb_pkg::wb_req_t wbm_req_i,
  output wb_pkg::wb_rsp_t wbm_rsp_o
);

  wb_pkg::wbs_req_t               slv_req [map_pkg::NUM_SLAVES];
  wb_pkg::wb_rsp_t                slv_rsp [map_pkg::NUM_SLAVES];
  logic [map_pkg::NUM_SLAVES-1:0] slv_ack;
  logic [map_pkg::NUM_SLAVES-1:0] active;
  logic                           dec_err;
  logic                           done;

  wbs_decoder u_decoder (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbm_req_i (wbm_req_i),
    .slv_ack_i (slv_ack),
    .done_i    (done),
    .wbs_req_o (slv_req),
    .active_o  (active),
    .dec_err_o (dec_err)
  );

  // one register bank per address window
  for (genvar i = 0; i < map_pkg::NUM_SLAVES; i++) begin : g_slave
    wb_reg_slave u_slave (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .req_i    (slv_req[i]),
      .rsp_o    (slv_rsp[i])
    );

    assign slv_ack[i] = slv_rsp[i].ack;
  end

  wbs_resp_mux u_resp_mux (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .slv_rsp_i (slv_rsp),
    .active_i  (active),
    .dec_err_i (dec_err),
    .wbm_rsp_o (wbm_rsp_o),
    .done_o    (done)
  );

endmodule

//--- testbench/wb_interconnect_assert.sv
`timescale 1ns/1ps

module wb_interconnect_assert (
  input logic             wb_clk_i,
  input logic             wb_rst_i,
  input wb_pkg::wb_req_t  wbm_req_i,
  input wb_pkg::wb_rsp_t  wbm_rsp_i,
  input wb_pkg::wbs_req_t slv_req_i [map_pkg::NUM_SLAVES]
);

  logic [map_pkg::NUM_SLAVES-1:0] stb;

  for (genvar i = 0; i < map_pkg::NUM_SLAVES; i++) begin : g_stb
    assign stb[i] = slv_req_i[i].stb;
  end

  a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wbm_rsp_i.ack && wbm_rsp_i.err))
    else $error("ack and err high in the same cycle");

  a_one_stb: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $onehot0(stb))
    else $error("more than one slave strobe high");

  // a strobe never stretches into a second cycle
  a_stb_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (|stb) |=> !(|stb))
    else $error("slave strobe held longer than one cycle");

  a_rsp_in_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $rose(wbm_rsp_i.ack || wbm_rsp_i.err) |-> wbm_req_i.cyc)
    else $error("master response raised outside a bus cycle");

endmodule

bind wb_interconnect_top wb_interconnect_assert u_assert (
  .wb_clk_i  (wb_clk_i),
  .wb_rst_i  (wb_rst_i),
  .wbm_req_i (wbm_req_i),
  .wbm_rsp_i (wbm_rsp_o),
  .slv_req_i (slv_req)
);

//--- testbench/tb_wb_interconnect.sv
`timescale 1ns/1ps

module tb_wb_interconnect;

  localparam int NS = map_pkg::NUM_SLAVES;
  localparam int NR = map_pkg::REG_COUNT;
  localparam int ALL_REGS = NS * NR;
  localparam int N_MISS = 16;
  localparam int N_TMO = 16;
  localparam int N_MIX = 300;
  // seven full register sweeps over the first five tests
  localparam int NUM_TXN = 7 * ALL_REGS + N_MISS + N_TMO + N_MIX;

  // edges from the drive edge to the response
  // the first edge only loads the decoder input register
  localparam int HIT_LAT = 1 + 3;
  localparam int MISS_LAT = 1 + 2;
  localparam int TMO_LAT = 1 + 1 + map_pkg::TIMEOUT_CYCLES + 2;
  localparam int XFER_LIMIT = map_pkg::TIMEOUT_CYCLES + 8;
  localparam int WATCHDOG_NS = NUM_TXN * (map_pkg::TIMEOUT_CYCLES + 8) * 10 + 3 * 10;

  typedef logic [$clog2(NS)-1:0] sidx_t;
  typedef logic [map_pkg::REG_IDX_W-1:0] widx_t;
  typedef enum logic [1:0] {K_ACK, K_DECODE_ERR, K_TIMEOUT} kind_t;

  typedef struct packed {
    kind_t                    kind;
    logic                     we;
    logic [wb_pkg::ADR_W-1:0] adr;
    logic [wb_pkg::DAT_W-1:0] dat;
  } expect_t;

  logic                     wb_clk_i = 1'b0;
  logic                     wb_rst_i = 1'b1;
  wb_pkg::wb_req_t          wbm_req = '0;
  wb_pkg::wb_rsp_t          wbm_rsp;
  logic [31:0]              lcg_state = 32'ha769;
  logic [wb_pkg::DAT_W-1:0] shadow [NS][NR];
  expect_t                  exp_q [$];
  int                       fail_count = 0;
  int                       txn_count = 0;
  int                       test_num = 0;
  int                       lat = 0;
  logic                     cyc_prev = 1'b0;

  wb_interconnect_top u_wb_interconnect_top (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbm_req_i (wbm_req),
    .wbm_rsp_o (wbm_rsp)
  );

  always #5 wb_clk_i = ~wb_clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // slave index of the window holding adr or -1 on a miss
  function automatic int window_of(input logic [wb_pkg::ADR_W-1:0] adr);
    logic [wb_pkg::ADR_W-1:0] base;
    int s;
    s = -1;
    for (int i = 0; i < NS; i++) begin
      base = map_pkg::SLAVE_BASE[sidx_t'(i)];
      if (adr >= base && adr < base + map_pkg::SLAVE_SPAN) begin
        s = i;
      end
    end
    return s;
  endfunction

  function automatic logic [31:0] reg_addr(input sidx_t s, input widx_t w);
    return map_pkg::SLAVE_BASE[s] + (32'(w) << 2);
  endfunction

  // upper half of a window starting right past the last backed word
  function automatic logic [31:0] unbacked_addr(input sidx_t s, input logic [2:0] k);
    return map_pkg::SLAVE_BASE[s] + (32'(NR) << 2) + (32'(k) << 2);
  endfunction

  function automatic logic [31:0] miss_addr();
    logic [31:0] a;
    a = lcg_next() & 32'h0000_7ffc;
    while (window_of(a) >= 0) begin
      a = lcg_next() & 32'h0000_7ffc;
    end
    return a;
  endfunction

  // expected outcome of one transfer; writes update the shadow by byte lane
  function automatic expect_t predict(input logic we, input logic [wb_pkg::SEL_W-1:0] sel,
                                      input logic [wb_pkg::ADR_W-1:0] adr,
                                      input logic [wb_pkg::DAT_W-1:0] dat);
    expect_t e;
    int s;
    int w;
    logic [wb_pkg::DAT_W-1:0] mask;
    e = '{kind: K_ACK, we: we, adr: adr, dat: '0};
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    s = window_of(adr);
    if (s < 0) begin
      e.kind = K_DECODE_ERR;
    end else begin
      w = int'((adr - map_pkg::SLAVE_BASE[sidx_t'(s)]) >> 2);
      if (w >= NR) begin
        e.kind = K_TIMEOUT;
      end else begin
        e.dat = shadow[sidx_t'(s)][widx_t'(w)];
        if (we) begin
          shadow[sidx_t'(s)][widx_t'(w)] = (e.dat & ~mask) | (dat & mask);
        end
      end
    end
    return e;
  endfunction

  task automatic run_transfer(input logic we, input logic [wb_pkg::SEL_W-1:0] sel,
                              input logic [wb_pkg::ADR_W-1:0] adr,
                              input logic [wb_pkg::DAT_W-1:0] dat);
    int waited;
    exp_q.push_back(predict(we, sel, adr, dat));
    waited = 0;
    @(posedge wb_clk_i);
    wbm_req <= '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
    do begin
      @(negedge wb_clk_i);
      waited++;
    end while (!(wbm_rsp.ack || wbm_rsp.err) && waited < XFER_LIMIT);
    assert (wbm_rsp.ack || wbm_rsp.err) else begin
      $display("no response within %0d cycles for address %h", XFER_LIMIT, adr);
      fail_count++;
      exp_q.delete();
    end
    @(posedge wb_clk_i);
    wbm_req <= '0;
    txn_count++;
  endtask

  // one pass over every backed register of every slave
  task automatic sweep(input logic we, input logic full);
    logic [31:0] r;
    for (int k = 0; k < ALL_REGS; k++) begin
      r = lcg_next();
      run_transfer(we, full ? 4'hf : r[31:28], reg_addr(sidx_t'(k / NR), widx_t'(k % NR)),
                   lcg_next());
    end
  endtask

  task automatic report_test(input string name, input int t0, input int f0);
    test_num++;
    $display("test %0d %s: %0d transfers, %0d errors", test_num, name, txn_count - t0,
             fail_count - f0);
  endtask

  // compare process samples away from the active edge
  always @(negedge wb_clk_i) begin
    expect_t e;
    int exp_lat;
    lat = (wbm_req.cyc && !cyc_prev) ? 0 : lat + 1;
    cyc_prev = wbm_req.cyc;
    if (!wb_rst_i && (wbm_rsp.ack || wbm_rsp.err)) begin
      assert (exp_q.size() > 0) else begin
        $display("response arrived with no transfer outstanding");
        fail_count++;
      end
      if (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        exp_lat = (e.kind == K_ACK) ? HIT_LAT : (e.kind == K_DECODE_ERR) ? MISS_LAT : TMO_LAT;
        if (e.kind == K_ACK) begin
          assert (wbm_rsp.ack && !wbm_rsp.err) else begin
            $display("wrong response at address %h: expected an ack, got an error", e.adr);
            fail_count++;
          end
          assert (e.we || wbm_rsp.dat == e.dat) else begin
            $display("Mismatch wbm_rsp_o.dat at address %h: expected %h, got %h",
                     e.adr, e.dat, wbm_rsp.dat);
            fail_count++;
          end
        end else begin
          assert (wbm_rsp.err && !wbm_rsp.ack) else begin
            $display("wrong response at address %h: expected an error, got an ack", e.adr);
            fail_count++;
          end
        end
        assert (lat == exp_lat) else begin
          $display("Mismatch response latency at address %h: expected %h, got %h",
                   e.adr, exp_lat, lat);
          fail_count++;
        end
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    int t0;
    int f0;
    for (int k = 0; k < ALL_REGS; k++) begin
      shadow[sidx_t'(k / NR)][widx_t'(k % NR)] = '0;
    end
    repeat (3) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    @(negedge wb_clk_i);
    assert (!wbm_rsp.ack && !wbm_rsp.err) else begin
      $display("master response active right after reset");
      fail_count++;
    end

    t0 = txn_count;
    f0 = fail_count;
    sweep(1'b0, 1'b1);
    report_test("reset values", t0, f0);

    t0 = txn_count;
    f0 = fail_count;
    sweep(1'b1, 1'b1);
    sweep(1'b0, 1'b1);
    report_test("full word write and read back", t0, f0);

    t0 = txn_count;
    f0 = fail_count;
    sweep(1'b1, 1'b0);
    sweep(1'b0, 1'b1);
    report_test("byte lane writes", t0, f0);

    // first misses sit just past each window end
    t0 = txn_count;
    f0 = fail_count;
    for (int i = 0; i < N_MISS; i++) begin
      a = (i < NS) ? map_pkg::SLAVE_BASE[sidx_t'(i)] + map_pkg::SLAVE_SPAN : miss_addr();
      r = lcg_next();
      run_transfer(r[31], 4'hf, a, lcg_next());
    end
    sweep(1'b0, 1'b1);
    report_test("decode misses", t0, f0);

    t0 = txn_count;
    f0 = fail_count;
    for (int i = 0; i < N_TMO; i++) begin
      r = lcg_next();
      run_transfer(r[31], 4'hf, unbacked_addr(sidx_t'(i % NS), r[30:28]), lcg_next());
    end
    sweep(1'b0, 1'b1);
    report_test("unbacked offsets", t0, f0);

    t0 = txn_count;
    f0 = fail_count;
    for (int i = 0; i < N_MIX; i++) begin
      r = lcg_next();
      case (r[31:29])
        3'd5: a = unbacked_addr(sidx_t'(r[28:27]), r[26:24]);
        3'd6: a = miss_addr();
        default: a = reg_addr(sidx_t'(r[28:27]), widx_t'(r[26:24]));
      endcase
      run_transfer(r[23], r[22:19], a, lcg_next());
    end
    report_test("random mix", t0, f0);

    $display("total %0d transfers, %0d errors", txn_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, %0d of %0d transfers done",
             WATCHDOG_NS, txn_count, NUM_TXN);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- project.f
design/wb_pkg.sv
design/map_pkg.sv
design/wbs_decoder.sv
design/wb_reg_slave.sv
design/wbs_resp_mux.sv
design/wb_interconnect_top.sv
testbench/wb_interconnect_assert.sv
testbench/tb_wb_interconnect.sv

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_wb_interconnect -f project.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
